/* sources.f */
design/msoc_pkg.sv
design/rx_majority.sv
design/uart_receiver.sv
design/rx_fifo.sv
design/periph_regs.sv
design/uart_transmitter.sv
design/msoc_periph_top.sv
sim/tb_clock_gen.sv
sim/tb_msoc_periph.sv

/* Makefile */
VERILATOR  ?= verilator
LINT_FLAGS  = --lint-only --timing
SIM_FLAGS   = --binary --timing --assert
TOP         = tb_msoc_periph
FILELIST    = sources.f
OBJ_DIR     = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run exits non-zero when the testbench stops with $fatal
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* sim/tb_msoc_periph.sv */
/*
  Self-checking testbench for the peripheral top level.
  uart_tx_o is looped back into uart_rx_i, so every sent byte lands in the
  receive queue. UART tests run at a divisor of 8. Stops at the first error.
*/
`default_nettype none

module tb_msoc_periph;

  import msoc_pkg::*;

  localparam int unsigned FIFO_DEPTH   = 8;
  localparam int unsigned LED_W        = 8;
  localparam int unsigned DIP_W        = 16;
  localparam int unsigned TEST_BAUD    = 8;
  localparam int unsigned CLK_PERIOD   = 20;
  localparam int unsigned RESET_CYCLES = 10;
  localparam int unsigned DRIVE_DELAY  = 2;
  localparam int unsigned SEED         = 32'hbee8_5955;

  typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_LED, OP_TXLINE, OP_DIP, OP_SEND, OP_HEAD} op_t;

  logic             msoc_clk;
  logic             rstn;
  logic             bus_req;
  logic             bus_we;
  addr_t            bus_addr;
  word_t            bus_wdata;
  word_t            bus_rdata;
  logic             uart_line;           // tx looped back to rx
  logic [DIP_W-1:0] dip;
  logic [LED_W-1:0] led;

  // stimulus table, one entry per index
  string       t_name[$];
  op_t         t_op[$];
  addr_t       t_addr[$];
  word_t       t_data[$];
  word_t       t_exp[$];
  logic        table_done;
  int          idx;

  tb_clock_gen #(.HALF_PERIOD(CLK_PERIOD / 2), .RESET_CYCLES(RESET_CYCLES)) u_tb_clock_gen
  (
    .msoc_clk (msoc_clk),
    .rstn     (rstn)
  );

  msoc_periph_top #(.RX_FIFO_DEPTH(FIFO_DEPTH), .LED_W(LED_W), .DIP_W(DIP_W)) u_msoc_periph_top
  (
    .msoc_clk    (msoc_clk),
    .rstn        (rstn),
    .bus_req_i   (bus_req),
    .bus_we_i    (bus_we),
    .bus_addr_i  (bus_addr),
    .bus_wdata_i (bus_wdata),
    .bus_rdata_o (bus_rdata),
    .uart_rx_i   (uart_line),
    .uart_tx_o   (uart_line),
    .dip_i       (dip),
    .led_o       (led)
  );

  ////////////////////////////////////////////////////////////
  // expected values and failure reporting

  function automatic addr_t reg_addr(input region_t region, input logic [3:0] ofs);
    reg_addr = (addr_t'(region) << 20) | (addr_t'(ofs) << 2);   // region 23..20, word 5..2
  endfunction

  function automatic word_t status_word(input byte_t head, input logic valid,
                                        input logic full, input logic ovf);
    status_word = {18'b0, 2'b00, ovf, full, 1'b0, valid, head};   // busy and error clear
  endfunction

  task automatic abort_run();
    $display("sim failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected)
    begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
    if (actual !== expected)
    begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      $display("ERR %s expected %b actual %b", name, expected, actual);
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // bus access drives 2 units after the rising edge

  task automatic step();
    @(posedge msoc_clk);
    #(DRIVE_DELAY);
  endtask

  task automatic bus_write(input addr_t addr, input word_t data);
    bus_req   = 1'b1;
    bus_we    = 1'b1;
    bus_addr  = addr;
    bus_wdata = data;
    step();
    bus_req   = 1'b0;
    bus_we    = 1'b0;
  endtask

  task automatic bus_read(input addr_t addr, output word_t data);
    bus_req  = 1'b1;
    bus_we   = 1'b0;
    bus_addr = addr;
    #1 data  = bus_rdata;                // combinational read data
    step();
    bus_req  = 1'b0;
  endtask

  // wait until the frame has left the transmitter and the receiver is done
  task automatic wait_uart_idle();
    word_t st;
    step();                              // start pulse reaches the transmitter
    bus_read(reg_addr(REGION_UART_RX, 4'd0), st);
    while (st[13] || st[12])
      bus_read(reg_addr(REGION_UART_RX, 4'd0), st);
    step();                              // received byte gets pushed
  endtask

  task automatic check_status(input string name, input addr_t addr, input word_t expected);
    word_t st;
    bus_read(addr, st);
    check_bit({name, " valid"}, expected[8], st[8]);
    check_bit({name, " full"}, expected[10], st[10]);
    check_bit({name, " overflow"}, expected[11], st[11]);
    if (expected[8])
    begin
      check_byte({name, " head"}, expected[7:0], st[7:0]);
      check_bit({name, " frame error"}, expected[9], st[9]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // table

  task automatic add_entry(input string name, input op_t op, input addr_t addr,
                           input word_t data, input word_t expected);
    t_name.push_back(name);
    t_op.push_back(op);
    t_addr.push_back(addr);
    t_data.push_back(data);
    t_exp.push_back(expected);
  endtask

  task automatic build_table();
    int    i;
    int    r;
    word_t val;
    byte_t b;
    byte_t sent[$];
    addr_t rx_addr;
    addr_t io_addr;
    rx_addr = reg_addr(REGION_UART_RX, 4'd0);
    io_addr = reg_addr(REGION_BOARD_IO, 4'd0);
    add_entry("reset_tx_idle", OP_TXLINE, '0, '0, 32'd1);
    add_entry("reset_led", OP_LED, '0, '0, '0);
    add_entry("reset_status", OP_HEAD, rx_addr, '0, status_word(8'h00, 1'b0, 1'b0, 1'b0));
    add_entry("reset_baud", OP_READ, reg_addr(REGION_UART_CTRL, OFS_BAUD), '0, 32'd87);
    for (i = 0; i < 3; i++)
    begin
      val = word_t'($urandom);
      add_entry("led_write", OP_WRITE, io_addr, val, '0);
      add_entry("led_show", OP_LED, '0, '0, val & 32'h0000_00ff);
      val = word_t'($urandom) & 32'h0000_ffff;
      add_entry("dip_read", OP_DIP, io_addr, val, val);
    end
    add_entry("baud_write", OP_WRITE, reg_addr(REGION_UART_CTRL, OFS_BAUD), TEST_BAUD, '0);
    add_entry("baud_read", OP_READ, reg_addr(REGION_UART_CTRL, OFS_BAUD), '0, TEST_BAUD);
    add_entry("tx_byte_read", OP_READ, reg_addr(REGION_UART_CTRL, OFS_TX_BYTE), '0, '0);
    for (r = 0; r < 16; r++)
      if (r != 2 && r != 3 && r != 7)
        add_entry($sformatf("unmapped_%0d", r), OP_READ, reg_addr(region_t'(r), 4'(r)), '0, '0);
    for (i = 0; i < 4; i++)
    begin
      b = byte_t'($urandom);
      add_entry("loop_send", OP_SEND, reg_addr(REGION_UART_CTRL, OFS_TX_BYTE), word_t'(b), '0);
      add_entry("loop_head", OP_HEAD, rx_addr, '0, status_word(b, 1'b1, 1'b0, 1'b0));
      add_entry("loop_pop", OP_WRITE, rx_addr, '0, '0);
      add_entry("loop_empty", OP_HEAD, rx_addr, '0, status_word(8'h00, 1'b0, 1'b0, 1'b0));
    end
    // one byte more than the queue holds and no pops in between
    for (i = 0; i <= FIFO_DEPTH; i++)
    begin
      b = byte_t'($urandom);
      sent.push_back(b);
      add_entry("ovf_send", OP_SEND, reg_addr(REGION_UART_CTRL, OFS_TX_BYTE), word_t'(b), '0);
    end
    for (i = 0; i < FIFO_DEPTH; i++)
    begin
      add_entry($sformatf("ovf_head_%0d", i), OP_HEAD, rx_addr, '0,
                status_word(sent[i], 1'b1, i == 0, 1'b1));
      add_entry("ovf_pop", OP_WRITE, rx_addr, '0, '0);
    end
    add_entry("ovf_drained", OP_HEAD, rx_addr, '0, status_word(8'h00, 1'b0, 1'b0, 1'b1));
  endtask

  task automatic run_entry(input int n);
    word_t rdata;
    case (t_op[n])
      OP_WRITE:  bus_write(t_addr[n], t_data[n]);
      OP_READ:
      begin
        bus_read(t_addr[n], rdata);
        check_word(t_name[n], t_exp[n], rdata);
      end
      OP_LED:    check_byte(t_name[n], t_exp[n][7:0], led);
      OP_TXLINE: check_bit(t_name[n], t_exp[n][0], uart_line);
      OP_DIP:
      begin
        dip = t_data[n][DIP_W-1:0];
        step();
        step();
        dip = ~t_data[n][DIP_W-1:0];     // the read must still show the old value
        bus_read(t_addr[n], rdata);
        check_word(t_name[n], t_exp[n], rdata);
      end
      OP_SEND:
      begin
        bus_write(t_addr[n], t_data[n]);
        wait_uart_idle();
      end
      OP_HEAD:   check_status(t_name[n], t_addr[n], t_exp[n]);
      default:
      begin
        $display("unknown operation in table entry %0d", n);
        abort_run();
      end
    endcase
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence and watchdog

  initial
  begin
    void'($urandom(SEED));
    table_done = 1'b0;
    bus_req    = 1'b0;
    bus_we     = 1'b0;
    bus_addr   = '0;
    bus_wdata  = '0;
    dip        = '0;
    build_table();
    table_done = 1'b1;
    wait (rstn === 1'b1);
    step();
    for (idx = 0; idx < t_op.size(); idx++)
      run_entry(idx);
    $display("sim passed");
    $finish;
  end

  initial
  begin : watchdog
    longint unsigned limit;
    wait (table_done === 1'b1);
    limit = longint'(t_op.size()) * 12 * TEST_BAUD * CLK_PERIOD
          + (RESET_CYCLES + 2) * CLK_PERIOD;
    #(limit);
    $display("run timed out, the DUT did not finish the table in time");
    abort_run();
  end

endmodule

`default_nettype wire

/* sim/tb_clock_gen.sv */
/*
  Free-running clock of 20 time units per period.
  Reset is held low for the first 10 rising edges.
*/
`default_nettype none

module tb_clock_gen
  #(
  parameter int unsigned HALF_PERIOD  = 10,
  parameter int unsigned RESET_CYCLES = 10
  )
  (
  output logic msoc_clk,
  output logic rstn
  );

  initial
  begin
    msoc_clk = 1'b0;
    forever #(HALF_PERIOD) msoc_clk = ~msoc_clk;
  end

  initial
  begin
    rstn = 1'b0;
    repeat (RESET_CYCLES) @(posedge msoc_clk);
    #2 rstn = 1'b1;                      // released off the edge
  end

endmodule

`default_nettype wire

/* design/msoc_periph_top.sv */
/*
  Peripheral side of the SoC: UART with receive queue and board I/O.
  RX_FIFO_DEPTH is a power of two, at least 2. LED_W and DIP_W are at most 32.
*/
`default_nettype none

module msoc_periph_top
  #(
  parameter int unsigned RX_FIFO_DEPTH = 8,
  parameter int unsigned LED_W         = 8,
  parameter int unsigned DIP_W         = 16
  )
  (
  input  wire logic             msoc_clk,
  input  wire logic             rstn,
  input  wire logic             bus_req_i,
  input  wire logic             bus_we_i,
  input  wire msoc_pkg::addr_t  bus_addr_i,
  input  wire msoc_pkg::word_t  bus_wdata_i,
  output msoc_pkg::word_t       bus_rdata_o,
  input  wire logic             uart_rx_i,
  output logic                  uart_tx_o,
  input  wire logic [DIP_W-1:0] dip_i,
  output logic [LED_W-1:0]      led_o
  );

  import msoc_pkg::*;

  logic  rx_clean;
  logic  rx_valid;
  byte_t rx_byte;
  logic  rx_err;
  logic  rx_busy;
  byte_t fifo_head;
  logic  fifo_head_err;
  logic  fifo_empty;
  logic  fifo_full;
  logic  fifo_overflow;
  logic  pop;
  baud_t baud;
  logic  tx_start;
  byte_t tx_byte;
  logic  tx_busy;

  ////////////////////////////////////////////////////////////
  // receive path

  rx_majority u_rx_majority
  (
    .msoc_clk (msoc_clk),
    .rstn     (rstn),
    .line_i   (uart_rx_i),
    .clean_o  (rx_clean)
  );

  uart_receiver u_uart_receiver
  (
    .msoc_clk    (msoc_clk),
    .rstn        (rstn),
    .rx_i        (rx_clean),
    .baud_i      (baud),
    .valid_o     (rx_valid),
    .byte_o      (rx_byte),
    .frame_err_o (rx_err),
    .busy_o      (rx_busy)
  );

  rx_fifo #(.DEPTH(RX_FIFO_DEPTH)) u_rx_fifo
  (
    .msoc_clk    (msoc_clk),
    .rstn        (rstn),
    .push_i      (rx_valid),
    .push_data_i (rx_byte),
    .push_err_i  (rx_err),
    .pop_i       (pop),
    .head_data_o (fifo_head),
    .head_err_o  (fifo_head_err),
    .empty_o     (fifo_empty),
    .full_o      (fifo_full),
    .overflow_o  (fifo_overflow)
  );

  ////////////////////////////////////////////////////////////
  // registers and transmit path

  periph_regs #(.LED_W(LED_W), .DIP_W(DIP_W)) u_periph_regs
  (
    .msoc_clk      (msoc_clk),
    .rstn          (rstn),
    .bus_req_i     (bus_req_i),
    .bus_we_i      (bus_we_i),
    .bus_addr_i    (bus_addr_i),
    .bus_wdata_i   (bus_wdata_i),
    .bus_rdata_o   (bus_rdata_o),
    .dip_i         (dip_i),
    .led_o         (led_o),
    .rx_head_i     (fifo_head),
    .rx_head_err_i (fifo_head_err),
    .rx_empty_i    (fifo_empty),
    .rx_full_i     (fifo_full),
    .rx_overflow_i (fifo_overflow),
    .rx_busy_i     (rx_busy),
    .tx_busy_i     (tx_busy),
    .pop_o         (pop),
    .baud_o        (baud),
    .tx_start_o    (tx_start),
    .tx_byte_o     (tx_byte)
  );

  uart_transmitter u_uart_transmitter
  (
    .msoc_clk (msoc_clk),
    .rstn     (rstn),
    .start_i  (tx_start),
    .byte_i   (tx_byte),
    .baud_i   (baud),
    .tx_o     (uart_tx_o),
    .busy_o   (tx_busy)
  );

endmodule

`default_nettype wire

/* design/uart_transmitter.sv */
/*
  8N1 transmitter. A start while busy is ignored.
  Start bit appears one cycle after start_i, each bit lasts baud_i cycles.
*/
`default_nettype none

module uart_transmitter
  (
  input  wire logic            msoc_clk,
  input  wire logic            rstn,
  input  wire logic            start_i,
  input  wire msoc_pkg::byte_t byte_i,
  input  wire msoc_pkg::baud_t baud_i,
  output logic                 tx_o,
  output logic                 busy_o
  );

  import msoc_pkg::*;

  logic [9:0] shift_q;   // stop, data, start
  baud_t      cnt_q;
  logic [3:0] left_q;    // bit shifts still to come
  logic       busy_q;

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      shift_q <= '1;                     // idle high
      cnt_q   <= '0;
      left_q  <= '0;
      busy_q  <= 1'b0;
    end
    else if (!busy_q)
    begin
      if (start_i)
      begin
        shift_q <= {1'b1, byte_i, 1'b0};
        cnt_q   <= baud_i - 1'b1;
        left_q  <= 4'd9;
        busy_q  <= 1'b1;
      end
    end
    else if (cnt_q != '0)
      cnt_q <= cnt_q - 1'b1;
    else if (left_q == '0)
      busy_q <= 1'b0;                    // stop bit done
    else
    begin
      shift_q <= {1'b1, shift_q[9:1]};
      cnt_q   <= baud_i - 1'b1;
      left_q  <= left_q - 1'b1;
    end
  end

  assign tx_o   = shift_q[0];
  assign busy_o = busy_q;

endmodule

`default_nettype wire

/* design/periph_regs.sv */
/*
  Register block behind the memory-style bus. Reads are combinational,
  writes act on the edge where req and we are both high.
  The bus master must not write the transmit byte on two cycles in a row.
*/
`default_nettype none

module periph_regs
  #(
  parameter int unsigned LED_W = 8,
  parameter int unsigned DIP_W = 16
  )
  (
  input  wire logic             msoc_clk,
  input  wire logic             rstn,
  input  wire logic             bus_req_i,
  input  wire logic             bus_we_i,
  input  wire msoc_pkg::addr_t  bus_addr_i,
  input  wire msoc_pkg::word_t  bus_wdata_i,
  output msoc_pkg::word_t       bus_rdata_o,
  input  wire logic [DIP_W-1:0] dip_i,
  output logic [LED_W-1:0]      led_o,
  input  wire msoc_pkg::byte_t  rx_head_i,
  input  wire logic             rx_head_err_i,
  input  wire logic             rx_empty_i,
  input  wire logic             rx_full_i,
  input  wire logic             rx_overflow_i,
  input  wire logic             rx_busy_i,
  input  wire logic             tx_busy_i,
  output logic                  pop_o,
  output msoc_pkg::baud_t       baud_o,
  output logic                  tx_start_o,
  output msoc_pkg::byte_t       tx_byte_o
  );

  import msoc_pkg::*;

  region_t          region;
  logic [3:0]       ofs;
  logic             bus_wr;
  logic             sel_ctrl;
  logic             sel_rx;
  logic             sel_io;
  logic             tx_wr;
  logic             baud_wr;
  logic [LED_W-1:0] led_q;
  baud_t            baud_q;
  logic             tx_start_q;
  byte_t            tx_byte_q;
  logic [DIP_W-1:0] dip_q;
  word_t            status;
  word_t            ctrl_rdata;

  ////////////////////////////////////////////////////////////
  // decode

  assign region   = bus_addr_i[REGION_HI:REGION_LO];
  assign ofs      = bus_addr_i[OFS_HI:OFS_LO];
  assign bus_wr   = bus_req_i & bus_we_i;
  assign sel_ctrl = (region == REGION_UART_CTRL);
  assign sel_rx   = (region == REGION_UART_RX);
  assign sel_io   = (region == REGION_BOARD_IO);
  assign tx_wr    = bus_wr & sel_ctrl & (ofs == OFS_TX_BYTE);
  assign baud_wr  = bus_wr & sel_ctrl & (ofs == OFS_BAUD);
  assign pop_o    = bus_wr & sel_rx;    // any write to region 3 pops

  ////////////////////////////////////////////////////////////
  // registers

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      led_q      <= '0;
      baud_q     <= BAUD_RESET;
      tx_start_q <= 1'b0;
    end
    else
    begin
      tx_start_q <= tx_wr;               // one cycle pulse
      if (bus_wr && sel_io)
        led_q <= bus_wdata_i[LED_W-1:0];
      if (baud_wr)
        baud_q <= bus_wdata_i[$bits(baud_t)-1:0];
    end
  end

  always_ff @(posedge msoc_clk)
  begin
    dip_q <= dip_i;                      // switches, one cycle behind
    if (tx_wr)
      tx_byte_q <= bus_wdata_i[7:0];
  end

  assign led_o      = led_q;
  assign baud_o     = baud_q;
  assign tx_start_o = tx_start_q;
  assign tx_byte_o  = tx_byte_q;

  ////////////////////////////////////////////////////////////
  // read data

  always_comb
  begin
    status                                 = '0;
    status[ST_HEAD_LSB +: $bits(byte_t)]   = rx_head_i;
    status[ST_VALID]                       = ~rx_empty_i;
    status[ST_FRAME_ERR]                   = rx_head_err_i;
    status[ST_FULL]                        = rx_full_i;
    status[ST_OVERFLOW]                    = rx_overflow_i;
    status[ST_RX_BUSY]                     = rx_busy_i;
    status[ST_TX_BUSY]                     = tx_busy_i;
  end

  assign ctrl_rdata  = (ofs == OFS_BAUD) ? word_t'(baud_q) : '0;   // only baud reads back
  assign bus_rdata_o = ({$bits(word_t){sel_ctrl}} & ctrl_rdata)
                     | ({$bits(word_t){sel_rx}} & status)
                     | ({$bits(word_t){sel_io}} & word_t'(dip_q));

  tx_start_pulse: assert property (@(posedge msoc_clk) disable iff (!rstn)
    tx_start_o |=> !tx_start_o);

endmodule

`default_nettype wire

/* design/rx_fifo.sv */
/*
  Circular queue of received bytes with their framing error bit.
  DEPTH must be a power of two, at least 2. A push into a full queue
  is dropped and sets overflow, which stays set until reset.
*/
`default_nettype none

module rx_fifo
  #(
  parameter int unsigned DEPTH = 8
  )
  (
  input  wire logic            msoc_clk,
  input  wire logic            rstn,
  input  wire logic            push_i,
  input  wire msoc_pkg::byte_t push_data_i,
  input  wire logic            push_err_i,
  input  wire logic            pop_i,
  output msoc_pkg::byte_t      head_data_o,
  output logic                 head_err_o,
  output logic                 empty_o,
  output logic                 full_o,
  output logic                 overflow_o
  );

  import msoc_pkg::*;

  localparam int unsigned AW = $clog2(DEPTH);

  typedef logic [AW:0] ptr_t;   // extra msb tells full from empty

  byte_t data_mem [DEPTH];
  logic  err_mem [DEPTH];
  ptr_t  wr_ptr_q;
  ptr_t  rd_ptr_q;
  ptr_t  count;
  logic  do_push;
  logic  do_pop;

  assign empty_o = (wr_ptr_q == rd_ptr_q);
  assign full_o  = (wr_ptr_q[AW] != rd_ptr_q[AW]) && (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;     // pop of empty queue is a no-op

  always_ff @(posedge msoc_clk)
  begin
    if (do_push)
    begin
      data_mem[wr_ptr_q[AW-1:0]] <= push_data_i;
      err_mem[wr_ptr_q[AW-1:0]]  <= push_err_i;
    end
  end

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      overflow_o <= 1'b0;
    end
    else
    begin
      if (do_push)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      if (push_i && full_o)
        overflow_o <= 1'b1;              // sticky
    end
  end

  assign head_data_o = data_mem[rd_ptr_q[AW-1:0]];
  assign head_err_o  = err_mem[rd_ptr_q[AW-1:0]];
  assign count       = wr_ptr_q - rd_ptr_q;

  count_bound: assert property (@(posedge msoc_clk) disable iff (!rstn) count <= ptr_t'(DEPTH));

endmodule

`default_nettype wire

/* design/uart_receiver.sv */
/*
  8N1 receiver, LSB first. rx_i must already be synchronous to msoc_clk.
  baud_i is cycles per bit and should not change during a frame.
  A low stop bit still delivers the byte, with frame_err_o set.
*/
`default_nettype none

module uart_receiver
  (
  input  wire logic            msoc_clk,
  input  wire logic            rstn,
  input  wire logic            rx_i,
  input  wire msoc_pkg::baud_t baud_i,
  output logic                 valid_o,
  output msoc_pkg::byte_t      byte_o,
  output logic                 frame_err_o,
  output logic                 busy_o
  );

  import msoc_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

  state_t     state_q;
  baud_t      cnt_q;      // cycles left to the next sample point
  logic [2:0] bit_q;      // data bit index
  logic       rx_prev_q;
  byte_t      data_q;
  logic       tick;

  assign tick = (cnt_q == '0);

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      state_q     <= S_IDLE;
      cnt_q       <= '0;
      bit_q       <= '0;
      rx_prev_q   <= 1'b1;
      valid_o     <= 1'b0;
      frame_err_o <= 1'b0;
    end
    else
    begin
      rx_prev_q <= rx_i;
      valid_o   <= 1'b0;
      if (state_q != S_IDLE && !tick)
        cnt_q <= cnt_q - 1'b1;
      case (state_q)
        S_IDLE:
          if (rx_prev_q && !rx_i)            // falling edge
          begin
            state_q <= S_START;
            cnt_q   <= baud_i >> 1;          // go to middle of start bit
          end
        S_START:
          if (tick)
          begin
            state_q <= rx_i ? S_IDLE : S_DATA;   // high here was a glitch
            cnt_q   <= baud_i - 1'b1;
            bit_q   <= '0;
          end
        S_DATA:
          if (tick)
          begin
            cnt_q <= baud_i - 1'b1;
            bit_q <= bit_q + 1'b1;
            if (bit_q == 3'd7)
              state_q <= S_STOP;
          end
        default:
          if (tick)
          begin
            state_q     <= S_IDLE;
            valid_o     <= 1'b1;
            frame_err_o <= ~rx_i;            // stop bit must be high
          end
      endcase
    end
  end

  always_ff @(posedge msoc_clk)
  begin
    if (state_q == S_DATA && tick)
      data_q <= {rx_i, data_q[7:1]};        // lsb arrives first
  end

  assign byte_o = data_q;
  assign busy_o = (state_q != S_IDLE);

  baud_legal: assert property (@(posedge msoc_clk) disable iff (!rstn) baud_i >= BAUD_MIN);

endmodule

`default_nettype wire

/* design/rx_majority.sv */
/*
  Two-stage synchroniser followed by a vote over three samples.
  Adds about four cycles of latency on the receive line.
*/
`default_nettype none

module rx_majority
  (
  input  wire logic msoc_clk,
  input  wire logic rstn,
  input  wire logic line_i,
  output logic      clean_o
  );

  logic [1:0] sync_q;   // metastability stages
  logic [1:0] hist_q;   // two older synchronised samples

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      sync_q <= 2'b11;    // idle line is high
      hist_q <= 2'b11;
    end
    else
    begin
      sync_q <= {sync_q[0], line_i};
      hist_q <= {hist_q[0], sync_q[1]};
    end
  end

  // two out of three wins
  assign clean_o = (sync_q[1] & hist_q[0]) | (sync_q[1] & hist_q[1]) | (hist_q[0] & hist_q[1]);

endmodule

`default_nettype wire

/* design/msoc_pkg.sv */
/*
  Shared types and constants of the peripheral block.
  Address bits 23..20 pick the region, bits 5..2 the register in it.
*/
`default_nettype none

package msoc_pkg;

  typedef logic [31:0] addr_t;   // bus address
  typedef logic [31:0] word_t;   // bus data word
  typedef logic [7:0]  byte_t;   // serial data byte
  typedef logic [15:0] baud_t;   // clock cycles per serial bit
  typedef logic [3:0]  region_t;

  // address fields
  localparam int unsigned REGION_HI = 23;
  localparam int unsigned REGION_LO = 20;
  localparam int unsigned OFS_HI    = 5;
  localparam int unsigned OFS_LO    = 2;

  localparam region_t REGION_UART_CTRL = 4'd2;
  localparam region_t REGION_UART_RX   = 4'd3;
  localparam region_t REGION_BOARD_IO  = 4'd7;

  localparam logic [3:0] OFS_TX_BYTE = 4'd0;
  localparam logic [3:0] OFS_BAUD    = 4'd1;

  localparam baud_t BAUD_RESET = 16'd87;
  localparam baud_t BAUD_MIN   = 16'd4;   // below this mid-bit sampling breaks

  // receive status word, unlisted bits read zero
  localparam int unsigned ST_HEAD_LSB  = 0;
  localparam int unsigned ST_VALID     = 8;
  localparam int unsigned ST_FRAME_ERR = 9;
  localparam int unsigned ST_FULL      = 10;
  localparam int unsigned ST_OVERFLOW  = 11;
  localparam int unsigned ST_RX_BUSY   = 12;
  localparam int unsigned ST_TX_BUSY   = 13;

endpackage

`default_nettype wire
